//--- design/ifu_pkg.sv
// ifu_pkg
// Shared widths, reset PC and instruction ROM sizing for the RV32 fetch front end.

package ifu_pkg;

    // bus widths
    localparam int INST_ADDR_WIDTH = 32;    // byte address into instruction space
    localparam int INST_DATA_WIDTH = 32;    // one RV32 instruction word

    // program counter
    localparam logic [INST_ADDR_WIDTH-1:0] PC_RESET_ADDR = 32'h0000_0000;  // boot vector
    localparam int PC_STEP = 4;             // bytes per sequential fetch

    // instruction rom
    localparam int MEM_DEPTH_WORDS = 64;    // words in the rom image
    localparam int MEM_ADDR_WIDTH  = $clog2(MEM_DEPTH_WORDS);  // word index bits

    // read port timing
    localparam int MEM_WAIT_CYCLES = 2;     // arready low cycles after an accept
    localparam int MEM_WAIT_WIDTH  = $clog2(MEM_WAIT_CYCLES + 1);  // wait counter bits

    // rom image also read by the testbench model
    localparam string MEM_INIT_FILE = "inst_mem.hex";

    // in-flight request tracking in the fetch unit
    // at most one request in the request stage and one in the response stage
    localparam int INFLIGHT_WIDTH = 2;

endpackage

//--- design/ifu_pipe.sv
// ifu_pipe
// IF/ID pipeline register. Carries instruction word, its address and a valid bit
// into decode. Flush kills the valid bit and wins over stall; stall freezes
// all three outputs.

`timescale 1ns/100ps

module ifu_pipe (
    input  logic                                clk,
    input  logic                                rst_n_i,

    input  logic [ifu_pkg::INST_DATA_WIDTH-1:0] inst_i,        // word from memory
    input  logic [ifu_pkg::INST_ADDR_WIDTH-1:0] inst_addr_i,   // its address
    input  logic                                inst_valid_i,  // word is real
    input  logic                                flush_flag_i,  // kill stage contents
    input  logic                                stall_i,       // hold stage contents

    output logic [ifu_pkg::INST_DATA_WIDTH-1:0] inst_o,
    output logic [ifu_pkg::INST_ADDR_WIDTH-1:0] inst_addr_o,
    output logic                                inst_valid_o
);

    logic load_payload;  // payload capture enable

    // payload moves whenever the stage is not frozen
    // a flushed word is don't-care since valid drops
    assign load_payload = !stall_i && !flush_flag_i;

    // valid bit is the control state
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;                 // nothing in decode after reset
        end else if (flush_flag_i) begin
            inst_valid_o <= 1'b0;                 // flush beats stall
        end else if (!stall_i) begin
            inst_valid_o <= inst_valid_i;         // normal advance
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (load_payload) begin
            inst_o      <= inst_i;
            inst_addr_o <= inst_addr_i;
        end
    end

    // a flushed stage must be empty on the following cycle, even under stall
    a_flush_clears: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        flush_flag_i |=> !inst_valid_o
    ) else $error("ifu_pipe: valid still set after flush");

endmodule

//--- design/ifu_ifetch.sv
// ifu_ifetch
// Program counter and next-PC select for the fetch stage. Issues the fetch
// request toward the instruction memory, squashes responses that were already
// in flight when a jump redirects the PC, and feeds the IF/ID register.

`timescale 1ns/100ps

module ifu_ifetch (
    input  logic                                clk,
    input  logic                                rst_n_i,

    input  logic                                jump_flag_i,    // redirect strobe
    input  logic [ifu_pkg::INST_ADDR_WIDTH-1:0] jump_addr_i,    // redirect target
    input  logic                                stall_pc_i,     // pc freeze
    input  logic                                axi_arready_i,  // memory can take a read

    // toward ifu_pipe
    input  logic [ifu_pkg::INST_DATA_WIDTH-1:0] inst_i,
    input  logic [ifu_pkg::INST_ADDR_WIDTH-1:0] inst_addr_i,
    input  logic                                flush_flag_i,
    input  logic                                inst_valid_i,
    input  logic                                stall_if_i,

    output logic [ifu_pkg::INST_ADDR_WIDTH-1:0] pc_o,
    output logic                                fetch_req_o,    // read request level

    output logic [ifu_pkg::INST_DATA_WIDTH-1:0] inst_o,
    output logic [ifu_pkg::INST_ADDR_WIDTH-1:0] inst_addr_o,
    output logic                                inst_valid_o
);
    import ifu_pkg::*;

    logic [INST_ADDR_WIDTH-1:0] pc_nxt;
    logic                       pc_hold;         // stall or memory busy
    logic                       accept;          // read taken this edge
    logic                       consume;         // response leaves memory this edge
    logic [INFLIGHT_WIDTH-1:0]  inflight_q;      // accepted, not yet consumed
    logic [INFLIGHT_WIDTH-1:0]  inflight_nxt;
    logic [INFLIGHT_WIDTH-1:0]  squash_q;        // stale responses still to drop
    logic                       drop_rsp;
    logic                       pipe_valid;      // response valid after squash

    assign fetch_req_o = !stall_pc_i && !jump_flag_i;   // no request on a redirect
    assign pc_hold     = stall_pc_i || !axi_arready_i;
    assign accept      = fetch_req_o && axi_arready_i;
    assign consume     = inst_valid_i && !stall_if_i;   // memory holds with the IF stall

    // jump first, then freeze, then sequential
    always_comb begin
        if (jump_flag_i) begin
            pc_nxt = jump_addr_i;
        end else if (pc_hold) begin
            pc_nxt = pc_o;
        end else begin
            pc_nxt = pc_o + INST_ADDR_WIDTH'(PC_STEP);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_o <= PC_RESET_ADDR;
        end else begin
            pc_o <= pc_nxt;
        end
    end

    // every request accepted before a jump belongs to the old path
    assign inflight_nxt = inflight_q + INFLIGHT_WIDTH'(accept) - INFLIGHT_WIDTH'(consume);
    assign drop_rsp     = jump_flag_i || (squash_q != '0);
    assign pipe_valid   = inst_valid_i && !drop_rsp;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inflight_q <= '0;
            squash_q   <= '0;
        end else begin
            inflight_q <= inflight_nxt;
            if (jump_flag_i) begin
                squash_q <= inflight_nxt;               // the rest still in memory
            end else if (consume && (squash_q != '0)) begin
                squash_q <= squash_q - INFLIGHT_WIDTH'(1);
            end
        end
    end

    ifu_pipe u_ifu_pipe (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .inst_addr_i (inst_addr_i),
        .inst_valid_i(pipe_valid),
        .flush_flag_i(flush_flag_i),
        .stall_i     (stall_if_i),
        .inst_o      (inst_o),
        .inst_addr_o (inst_addr_o),
        .inst_valid_o(inst_valid_o)
    );

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i) pc_o[1:0] == 2'b00
    ) else $error("ifu_ifetch: pc not word aligned");

    // pc only moves on a memory accept or a redirect
    a_pc_moves: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(accept || jump_flag_i) |=> $stable(pc_o)
    ) else $error("ifu_ifetch: pc changed without accept or jump");

endmodule

//--- design/inst_mem.sv
// inst_mem
// Instruction ROM read port. Takes a read when fetch_req and arready meet,
// then drops arready for MEM_WAIT_CYCLES cycles. The ROM is read one edge
// after the accept, so the response shows up two edges after it.
// hold freezes both the request stage and the response register.

`timescale 1ns/100ps

module inst_mem (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                fetch_req_i,  // read request level
    input  logic [ifu_pkg::INST_ADDR_WIDTH-1:0] addr_i,       // byte address of the read
    input  logic                                hold_i,       // downstream back-pressure
    output logic                                arready_o,    // read address ready level
    output logic [ifu_pkg::INST_DATA_WIDTH-1:0] rsp_inst_o,
    output logic [ifu_pkg::INST_ADDR_WIDTH-1:0] rsp_addr_o,
    output logic                                rsp_valid_o
);
    import ifu_pkg::*;

    logic [INST_DATA_WIDTH-1:0] rom [MEM_DEPTH_WORDS];
    logic [MEM_WAIT_WIDTH-1:0]  wait_cnt_q;   // wait states left
    logic                       arready_q;
    logic                       accept;
    logic                       req_valid_q;  // accepted read awaiting rom access
    logic [INST_ADDR_WIDTH-1:0] req_addr_q;
    logic [MEM_ADDR_WIDTH-1:0]  rom_idx;      // word index, wraps at the depth

    initial begin
        $readmemh(MEM_INIT_FILE, rom);
    end

    assign accept    = fetch_req_i && arready_q;
    assign arready_o = arready_q;
    assign rom_idx   = req_addr_q[MEM_ADDR_WIDTH+1:2];  // drop byte offset

    // ready goes low on accept and comes back as the count runs out
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wait_cnt_q <= '0;
            arready_q  <= 1'b1;                              // ready out of reset
        end else if (accept) begin
            wait_cnt_q <= MEM_WAIT_WIDTH'(MEM_WAIT_CYCLES);
            arready_q  <= 1'b0;
        end else if (wait_cnt_q != '0) begin
            wait_cnt_q <= wait_cnt_q - MEM_WAIT_WIDTH'(1);
            arready_q  <= (wait_cnt_q == MEM_WAIT_WIDTH'(1));  // last wait cycle
        end
    end

    // request stage
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_valid_q <= 1'b0;
        end else if (accept) begin
            req_valid_q <= 1'b1;
        end else if (!hold_i) begin
            req_valid_q <= 1'b0;                 // moved on to the response stage
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q <= addr_i;
        end
    end

    // response register, frozen by hold
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else if (!hold_i) begin
            rsp_valid_o <= req_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i && req_valid_q) begin
            rsp_inst_o <= rom[rom_idx];
            rsp_addr_o <= req_addr_q;
        end
    end

    a_wait_not_ready: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wait_cnt_q != '0) |-> !arready_o
    ) else $error("inst_mem: arready high during wait states");

    // an accept followed by a free edge yields a response
    a_rsp_latency: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (accept ##1 !hold_i) |=> rsp_valid_o
    ) else $error("inst_mem: response missing two edges after accept");

endmodule

//--- design/ifu_top.sv
// ifu_top
// Fetch subsystem. The fetch unit drives PC and the request level into the
// instruction ROM port. The ROM's ready level comes back to the PC logic, and
// its response enters the IF/ID register inside the fetch unit.
// stall_i freezes the PC, the ROM response and the IF/ID register together.

`timescale 1ns/100ps

module ifu_top (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                jump_i,        // one cycle redirect
    input  logic [ifu_pkg::INST_ADDR_WIDTH-1:0] jump_addr_i,
    input  logic                                flush_i,       // one cycle pipe kill
    input  logic                                stall_i,       // back-pressure level
    output logic [ifu_pkg::INST_ADDR_WIDTH-1:0] pc_o,
    output logic [ifu_pkg::INST_DATA_WIDTH-1:0] inst_o,
    output logic [ifu_pkg::INST_ADDR_WIDTH-1:0] inst_addr_o,
    output logic                                inst_valid_o
);
    import ifu_pkg::*;

    logic                       fetch_req;   // fetch unit wants a read
    logic                       arready;     // rom port can take it
    logic [INST_DATA_WIDTH-1:0] rsp_inst;
    logic [INST_ADDR_WIDTH-1:0] rsp_addr;
    logic                       rsp_valid;

    ifu_ifetch u_ifu_ifetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .jump_flag_i  (jump_i),
        .jump_addr_i  (jump_addr_i),
        .stall_pc_i   (stall_i),
        .axi_arready_i(arready),
        .inst_i       (rsp_inst),
        .inst_addr_i  (rsp_addr),
        .flush_flag_i (flush_i),
        .inst_valid_i (rsp_valid),
        .stall_if_i   (stall_i),
        .pc_o         (pc_o),
        .fetch_req_o  (fetch_req),
        .inst_o       (inst_o),
        .inst_addr_o  (inst_addr_o),
        .inst_valid_o (inst_valid_o)
    );

    inst_mem u_inst_mem (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch_req_i(fetch_req),
        .addr_i     (pc_o),        // current PC is the read address
        .hold_i     (stall_i),
        .arready_o  (arready),
        .rsp_inst_o (rsp_inst),
        .rsp_addr_o (rsp_addr),
        .rsp_valid_o(rsp_valid)
    );

endmodule

//--- tb/tb_clkgen.sv
// tb_clkgen
// Free running testbench clock, 50% duty cycle.

`timescale 1ns/100ps

module tb_clkgen #(
    parameter int PERIOD_NS = 100           // full clock period
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;  // half period per toggle
        end
    end

endmodule

//--- tb/tb_ifu_top.sv
// tb_ifu_top
// Testbench for the fetch subsystem. Runs reset, sequential fetch, wait state
// spacing, jump/flush and random stall tests. A small model tracks the next
// expected output address and a copy of the ROM; concurrent assertions compare.

`timescale 1ns/100ps

module tb_ifu_top;
    import ifu_pkg::*;

    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES  = 16;
    localparam int STALL_CYCLES  = 160;     // random stall stretch
    localparam int OUT_COUNT     = 42;      // valid outputs awaited over all tests
    localparam int BUBBLE_CYCLES = 16;      // redirect and flush bubbles
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 3 * OUT_COUNT + STALL_CYCLES
                                   + BUBBLE_CYCLES;
    localparam int OUT_TIMEOUT   = 40;      // cycles allowed per expected output

    logic                       clk;
    logic                       rst_n_i;
    logic                       jump_i;
    logic [INST_ADDR_WIDTH-1:0] jump_addr_i;
    logic                       flush_i;
    logic                       stall_i;
    logic [INST_ADDR_WIDTH-1:0] pc_o;
    logic [INST_DATA_WIDTH-1:0] inst_o;
    logic [INST_ADDR_WIDTH-1:0] inst_addr_o;
    logic                       inst_valid_o;

    logic [INST_DATA_WIDTH-1:0] rom_model [MEM_DEPTH_WORDS];
    logic [INST_ADDR_WIDTH-1:0] exp_addr;    // next address in program order
    logic [INST_DATA_WIDTH-1:0] exp_inst;
    logic                       loaded_q;    // pipe advanced at the last edge
    logic                       new_valid;   // fresh output this cycle
    logic                       resync;      // sequence broken by a lone flush
    logic                       seen_first;
    logic                       gap_en;      // spacing check active
    int                         gap;         // cycles since last fresh output
    int                         errors;
    int                         tests_run;
    int                         tests_failed;
    int                         seed;
    string                      cur_test;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clkgen (.clk_o(clk));

    ifu_top ifu_top_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .jump_i      (jump_i),
        .jump_addr_i (jump_addr_i),
        .flush_i     (flush_i),
        .stall_i     (stall_i),
        .pc_o        (pc_o),
        .inst_o      (inst_o),
        .inst_addr_o (inst_addr_o),
        .inst_valid_o(inst_valid_o)
    );

    initial begin
        $readmemh(MEM_INIT_FILE, rom_model);
    end

    assign new_valid = inst_valid_o && loaded_q;
    assign exp_inst  = rom_model[inst_addr_o[MEM_ADDR_WIDTH+1:2]];  // rom wraps at depth

    // reference model of the output order
    always @(posedge clk) begin
        if (!rst_n_i) begin
            exp_addr   <= PC_RESET_ADDR;
            loaded_q   <= 1'b0;
            resync     <= 1'b0;
            seen_first <= 1'b0;
            gap        <= 0;
        end else begin
            loaded_q <= !stall_i;                 // pipe moves only when not stalled
            gap      <= new_valid ? 1 : gap + 1;
            if (jump_i) begin
                exp_addr <= jump_addr_i;          // target comes next
                resync   <= 1'b0;
            end else if (flush_i) begin
                resync   <= 1'b1;                 // one word may be lost
            end else if (new_valid) begin
                // after a lone flush the next output sets the order again
                exp_addr <= resync ? inst_addr_o + INST_ADDR_WIDTH'(4)
                                   : exp_addr + INST_ADDR_WIDTH'(4);
                resync   <= 1'b0;
            end
            if (new_valid) begin
                seen_first <= 1'b1;
            end
        end
    end

    task automatic report_value(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        errors++;
        $display("FAILED %s (%s): expected %h, actual %h", cur_test, what, exp_v, act_v);
    endtask

    task automatic report_text(input string what);
        errors++;
        $display("error in %s: %s", cur_test, what);
    endtask

    a_reset_low: assert property (
        @(posedge clk) !rst_n_i |=> !inst_valid_o
    ) else report_text("valid output during reset");

    a_reset_release: assert property (
        @(posedge clk) $rose(rst_n_i) |=> !inst_valid_o
    ) else report_text("valid output on first edge after reset");

    a_reset_pc: assert property (
        @(posedge clk) $rose(rst_n_i) |-> pc_o == PC_RESET_ADDR
    ) else report_value("reset pc", PC_RESET_ADDR, $sampled(pc_o));

    // after a jump the model holds the target as the next address
    a_jump_pc: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        jump_i |=> pc_o == exp_addr
    ) else report_value("jump pc", $sampled(exp_addr), $sampled(pc_o));

    a_first_addr: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (new_valid && !seen_first) |-> inst_addr_o == PC_RESET_ADDR
    ) else report_value("first address", PC_RESET_ADDR, $sampled(inst_addr_o));

    a_rom_word: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        new_valid |-> inst_o == exp_inst
    ) else report_value("instruction word", $sampled(exp_inst), $sampled(inst_o));

    // also catches skipped, repeated and pre-jump addresses
    a_seq_addr: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (new_valid && !resync) |-> inst_addr_o == exp_addr
    ) else report_value("address order", $sampled(exp_addr), $sampled(inst_addr_o));

    a_gap: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (new_valid && gap_en) |-> gap == 3
    ) else report_value("output spacing", 32'd3, $sampled(gap));

    a_flush_clears: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !inst_valid_o
    ) else report_text("valid output still set after flush");

    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (stall_i && !flush_i) |=> ($stable(inst_o) && $stable(inst_addr_o)
                                   && $stable(inst_valid_o))
    ) else report_text("outputs changed during stall");

    // waits for a fresh output, gives up after a bound
    task automatic wait_output(input int count);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < count && cycles < count * OUT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (new_valid) begin
                seen++;
            end
        end
        if (seen < count) begin
            report_text("timed out waiting for a valid output");
        end
    endtask

    task automatic end_test(input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("test %-16s %s", cur_test, (errors == errors_before) ? "ok" : "with errors");
    endtask

    // jump and flush strobes seen by the DUT on the next edge
    task automatic do_jump(input logic [INST_ADDR_WIDTH-1:0] target);
        jump_i      <= 1'b1;
        flush_i     <= 1'b1;
        jump_addr_i <= target;
        @(posedge clk);
        jump_i      <= 1'b0;
        flush_i     <= 1'b0;
    endtask

    initial begin
        int start_err;
        jump_i       = 1'b0;
        jump_addr_i  = '0;
        flush_i      = 1'b0;
        stall_i      = 1'b0;
        rst_n_i      = 1'b0;
        gap_en       = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'h4b94;

        cur_test  = "reset";
        start_err = errors;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        wait_output(1);
        end_test(start_err);

        cur_test  = "sequential";
        start_err = errors;
        wait_output(1);
        gap_en <= 1'b1;
        wait_output(16);
        end_test(start_err);

        cur_test  = "wait_states";
        start_err = errors;
        wait_output(10);
        gap_en <= 1'b0;
        end_test(start_err);

        cur_test  = "jump_flush";
        start_err = errors;
        @(posedge clk);
        do_jump(32'h0000_0040);            // old word in the response stage
        wait_output(4);
        do_jump(32'h0000_0108);            // old word still in the request stage
        wait_output(3);
        @(posedge clk);
        flush_i <= 1'b1;                   // flush with no jump
        @(posedge clk);
        flush_i <= 1'b0;
        wait_output(3);
        end_test(start_err);

        cur_test  = "random_stall";
        start_err = errors;
        repeat (STALL_CYCLES) begin
            @(posedge clk);
            stall_i <= (($random(seed) & 3) == 0);  // about one cycle in four
        end
        @(posedge clk);
        stall_i <= 1'b0;
        wait_output(4);
        end_test(start_err);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TOTAL_CYCLES * 4 * CLK_PERIOD_NS);
        $display("watchdog expired before the tests completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- inst_mem.hex
// one 32-bit instruction word per line, word index 0 to 63
c0de0000
c0de0004
c0de0008
c0de000c
c0de0010
c0de0014
c0de0018
c0de001c
c0de0020
c0de0024
c0de0028
c0de002c
c0de0030
c0de0034
c0de0038
c0de003c
c0de0040
c0de0044
c0de0048
c0de004c
c0de0050
c0de0054
c0de0058
c0de005c
c0de0060
c0de0064
c0de0068
c0de006c
c0de0070
c0de0074
c0de0078
c0de007c
c0de0080
c0de0084
c0de0088
c0de008c
c0de0090
c0de0094
c0de0098
c0de009c
c0de00a0
c0de00a4
c0de00a8
c0de00ac
c0de00b0
c0de00b4
c0de00b8
c0de00bc
c0de00c0
c0de00c4
c0de00c8
c0de00cc
c0de00d0
c0de00d4
c0de00d8
c0de00dc
c0de00e0
c0de00e4
c0de00e8
c0de00ec
c0de00f0
c0de00f4
c0de00f8
c0de00fc

//--- files.f
design/ifu_pkg.sv
design/ifu_pipe.sv
design/ifu_ifetch.sv
design/inst_mem.sv
design/ifu_top.sv
tb/tb_clkgen.sv
tb/tb_ifu_top.sv

//--- Makefile
# Verilator build for the fetch subsystem testbench

VERILATOR  ?= verilator
FILELIST   ?= files.f
TB_TOP     ?= tb_ifu_top
RTL_TOP    ?= ifu_top
OBJ_DIR    ?= obj_dir
EXE        ?= Vtb_ifu_top
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
FAIL_MSG   := TESTBENCH FAILED
PASS_MSG   := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(OBJ_DIR)/$(EXE): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o $(EXE)

sim: $(OBJ_DIR)/$(EXE)
	./$(OBJ_DIR)/$(EXE) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
